/* hdl/lsu_data_ram.sv */
`default_nettype none

module lsu_data_ram (
  input  logic              i_clk,
  input  lsu_pkg::paddr_t   i_rd_addr,
  output lsu_pkg::xlen_t    o_rd_data,
  input  logic              i_wr_valid,
  input  lsu_pkg::paddr_t   i_wr_addr,
  input  lsu_pkg::byte_en_t i_wr_be,
  input  lsu_pkg::xlen_t    i_wr_data
);
  import lsu_pkg::*;

  localparam int WORD_IDX_W = PADDR_W - 3;
  localparam int DEPTH      = 2 ** WORD_IDX_W;

  xlen_t                 r_mem [DEPTH];
  xlen_t                 r_rd_data;
  logic [WORD_IDX_W-1:0] w_rd_word;
  logic [WORD_IDX_W-1:0] w_wr_word;

  assign w_rd_word = i_rd_addr[PADDR_W-1:3];
  assign w_wr_word = i_wr_addr[PADDR_W-1:3];

  initial begin
    for (int i = 0; i < DEPTH; i++) begin
      r_mem[i] = '0;
    end
  end

  // Read before write on same word
  always_ff @(posedge i_clk) begin
    if (i_wr_valid) begin
      for (int b = 0; b < BE_W; b++) begin
        if (i_wr_be[b]) r_mem[w_wr_word][b*8 +: 8] <= i_wr_data[b*8 +: 8];
      end
    end
    r_rd_data <= r_mem[w_rd_word];
  end

  assign o_rd_data = r_rd_data;

endmodule

`default_nettype wire

/* hdl/lsu_inst_decode.sv */
`default_nettype none

module lsu_inst_decode (
  input  lsu_pkg::inst_t     i_inst,
  output logic               o_is_load,
  output logic               o_is_store,
  output lsu_pkg::mem_size_t o_size,
  output logic               o_unsigned,
  output lsu_pkg::vaddr_t    o_imm,
  output lsu_pkg::reg_idx_t  o_rs1,
  output lsu_pkg::reg_idx_t  o_rs2,
  output lsu_pkg::reg_idx_t  o_rd
);
  import lsu_pkg::*;

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;

  assign w_opcode = i_inst[6:0];
  assign w_funct3 = i_inst[14:12];

  // funct3 111 is not a load, stores have no unsigned forms
  assign o_is_load  = (w_opcode == OPC_LOAD) && (w_funct3 != 3'b111);
  assign o_is_store = (w_opcode == OPC_STORE) && !w_funct3[2];

  assign o_size     = mem_size_t'(w_funct3[1:0]);
  assign o_unsigned = w_funct3[2];

  assign o_imm = o_is_store ?
                 {{(VADDR_W-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]} : // S-type
                 {{(VADDR_W-12){i_inst[31]}}, i_inst[31:20]};                // I-type

  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];
  assign o_rd  = i_inst[11:7];

endmodule

`default_nettype wire

/* hdl/lsu_pipe.sv */
`default_nettype none

module lsu_pipe (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  logic               i_issue_valid,
  input  lsu_pkg::inst_t     i_issue_inst,
  input  logic               i_replay_valid,
  input  lsu_pkg::inst_t     i_replay_inst,
  output logic               o_issue_conflicted,
  output lsu_pkg::inst_t     o_dec_inst,
  input  logic               i_dec_is_load,
  input  logic               i_dec_is_store,
  input  lsu_pkg::mem_size_t i_dec_size,
  input  logic               i_dec_unsigned,
  input  lsu_pkg::vaddr_t    i_dec_imm,
  input  lsu_pkg::reg_idx_t  i_dec_rs1,
  input  lsu_pkg::reg_idx_t  i_dec_rs2,
  input  lsu_pkg::reg_idx_t  i_dec_rd,
  output lsu_pkg::reg_idx_t  o_rs1,
  output lsu_pkg::reg_idx_t  o_rs2,
  input  lsu_pkg::xlen_t     i_rs1_data,
  input  lsu_pkg::xlen_t     i_rs2_data,
  output lsu_pkg::vpn_t      o_tlb_vpn,
  input  logic               i_tlb_hit,
  input  lsu_pkg::ppn_t      i_tlb_ppn,
  output logic               o_tlb_miss_valid,
  output lsu_pkg::vpn_t      o_tlb_miss_vpn,
  output lsu_pkg::paddr_t    o_ram_rd_addr,
  input  lsu_pkg::xlen_t     i_ram_rd_data,
  output logic               o_ram_wr_valid,
  output lsu_pkg::paddr_t    o_ram_wr_addr,
  output lsu_pkg::byte_en_t  o_ram_wr_be,
  output lsu_pkg::xlen_t     o_ram_wr_data,
  output logic               o_ld_wb_valid,
  output lsu_pkg::reg_idx_t  o_ld_wb_rd,
  output lsu_pkg::xlen_t     o_ld_wb_data
);
  import lsu_pkg::*;

  logic      r_ex0_issue_valid;
  inst_t     r_ex0_issue_inst;
  logic      w_ex0_mem_op;

  logic      r_ex1_valid;
  logic      r_ex1_is_load;
  mem_size_t r_ex1_size;
  logic      r_ex1_unsigned;
  vaddr_t    r_ex1_imm;
  reg_idx_t  r_ex1_rs1;
  reg_idx_t  r_ex1_rs2;
  reg_idx_t  r_ex1_rd;
  vaddr_t    w_ex1_vaddr;
  vpn_t      w_ex1_vpn;
  paddr_t    w_ex1_paddr;
  logic [2:0] w_ex1_ofs;
  logic [2:0] w_ex1_align_mask;
  byte_en_t  w_ex1_be_base;
  logic      w_ex1_go;

  logic      r_ex2_valid;
  mem_size_t r_ex2_size;
  logic      r_ex2_unsigned;
  reg_idx_t  r_ex2_rd;
  logic [2:0] r_ex2_ofs;
  xlen_t     w_ex2_shifted;
  xlen_t     w_ex2_data;

  logic      r_ex3_valid;
  reg_idx_t  r_ex3_rd;
  xlen_t     r_ex3_data;

  // Replay wins over the fresh issue in EX0
  assign o_dec_inst         = i_replay_valid ? i_replay_inst : r_ex0_issue_inst;
  assign o_issue_conflicted = i_replay_valid && r_ex0_issue_valid;
  assign w_ex0_mem_op       = (i_replay_valid || r_ex0_issue_valid) &&
                              (i_dec_is_load || i_dec_is_store);

  // EX1 address generation and translation
  assign o_rs1       = r_ex1_rs1;
  assign o_rs2       = r_ex1_rs2;
  assign w_ex1_vaddr = i_rs1_data[VADDR_W-1:0] + r_ex1_imm;
  assign w_ex1_vpn   = w_ex1_vaddr[VADDR_W-1:PAGE_OFS_W];
  assign w_ex1_paddr = {i_tlb_ppn, w_ex1_vaddr[PAGE_OFS_W-1:0]};
  assign w_ex1_ofs   = w_ex1_vaddr[2:0];
  assign w_ex1_go    = r_ex1_valid && i_tlb_hit;

  assign o_tlb_vpn        = w_ex1_vpn;
  assign o_tlb_miss_valid = r_ex1_valid && !i_tlb_hit; // Kills the access
  assign o_tlb_miss_vpn   = w_ex1_vpn;

  always_comb begin
    case (r_ex1_size)
      SIZE_B: begin
        w_ex1_be_base    = 8'h01;
        w_ex1_align_mask = 3'b000;
      end
      SIZE_H: begin
        w_ex1_be_base    = 8'h03;
        w_ex1_align_mask = 3'b001;
      end
      SIZE_W: begin
        w_ex1_be_base    = 8'h0f;
        w_ex1_align_mask = 3'b011;
      end
      default: begin
        w_ex1_be_base    = 8'hff;
        w_ex1_align_mask = 3'b111;
      end
    endcase
  end

  assign o_ram_rd_addr  = w_ex1_paddr;
  assign o_ram_wr_valid = w_ex1_go && !r_ex1_is_load;
  assign o_ram_wr_addr  = w_ex1_paddr;
  assign o_ram_wr_be    = w_ex1_be_base << w_ex1_ofs;            // Lane position
  assign o_ram_wr_data  = i_rs2_data << {w_ex1_ofs, 3'b000};

  // EX2 lane select and extension
  assign w_ex2_shifted = i_ram_rd_data >> {r_ex2_ofs, 3'b000};

  always_comb begin
    case (r_ex2_size)
      SIZE_B: w_ex2_data = r_ex2_unsigned ? {{(XLEN_W-8){1'b0}}, w_ex2_shifted[7:0]} :
                           {{(XLEN_W-8){w_ex2_shifted[7]}}, w_ex2_shifted[7:0]};
      SIZE_H: w_ex2_data = r_ex2_unsigned ? {{(XLEN_W-16){1'b0}}, w_ex2_shifted[15:0]} :
                           {{(XLEN_W-16){w_ex2_shifted[15]}}, w_ex2_shifted[15:0]};
      SIZE_W: w_ex2_data = r_ex2_unsigned ? {{(XLEN_W-32){1'b0}}, w_ex2_shifted[31:0]} :
                           {{(XLEN_W-32){w_ex2_shifted[31]}}, w_ex2_shifted[31:0]};
      default: w_ex2_data = w_ex2_shifted;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex0_issue_valid <= 1'b0;
      r_ex1_valid       <= 1'b0;
      r_ex2_valid       <= 1'b0;
      r_ex3_valid       <= 1'b0;
    end else begin
      r_ex0_issue_valid <= i_issue_valid;
      r_ex1_valid       <= w_ex0_mem_op;
      r_ex2_valid       <= w_ex1_go && r_ex1_is_load; // Stores retire in EX1
      r_ex3_valid       <= r_ex2_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_ex0_issue_inst <= i_issue_inst;
    r_ex1_is_load    <= i_dec_is_load;
    r_ex1_size       <= i_dec_size;
    r_ex1_unsigned   <= i_dec_unsigned;
    r_ex1_imm        <= i_dec_imm;
    r_ex1_rs1        <= i_dec_rs1;
    r_ex1_rs2        <= i_dec_rs2;
    r_ex1_rd         <= i_dec_rd;
    r_ex2_size       <= r_ex1_size;
    r_ex2_unsigned   <= r_ex1_unsigned;
    r_ex2_rd         <= r_ex1_rd;
    r_ex2_ofs        <= w_ex1_ofs;
    r_ex3_rd         <= r_ex2_rd;
    r_ex3_data       <= w_ex2_data;
  end

  assign o_ld_wb_valid = r_ex3_valid;
  assign o_ld_wb_rd    = r_ex3_rd;
  assign o_ld_wb_data  = r_ex3_data;

  a_ex1_aligned: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    r_ex1_valid |-> ((w_ex1_ofs & w_ex1_align_mask) == 3'b000));

  // Writeback traces back to a LOAD opcode in EX0 three cycles earlier
  a_wb_from_load: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    o_ld_wb_valid |-> $past(w_ex0_mem_op && (o_dec_inst[6:0] == OPC_LOAD), 3));

endmodule

`default_nettype wire

/* hdl/lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

  localparam int XLEN_W     = 64;
  localparam int VADDR_W    = 32;
  localparam int PADDR_W    = 16;
  localparam int PAGE_OFS_W = 12;

  localparam int VPN_W     = VADDR_W - PAGE_OFS_W;
  localparam int PPN_W     = PADDR_W - PAGE_OFS_W;
  localparam int REG_IDX_W = 5;
  localparam int INST_W    = 32;
  localparam int BE_W      = XLEN_W / 8;

  // Major opcodes handled by this pipe
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  typedef logic [XLEN_W-1:0]    xlen_t;
  typedef logic [VADDR_W-1:0]   vaddr_t;
  typedef logic [PADDR_W-1:0]   paddr_t;
  typedef logic [VPN_W-1:0]     vpn_t;
  typedef logic [PPN_W-1:0]     ppn_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;
  typedef logic [INST_W-1:0]    inst_t;
  typedef logic [BE_W-1:0]      byte_en_t;

  // Encoded as funct3[1:0] of the load/store
  typedef enum logic [1:0] {
    SIZE_B  = 2'd0,
    SIZE_H  = 2'd1,
    SIZE_W  = 2'd2,
    SIZE_DW = 2'd3
  } mem_size_t;

endpackage

`default_nettype wire

/* hdl/lsu_regfile.sv */
`default_nettype none

module lsu_regfile (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  lsu_pkg::reg_idx_t i_rs1,
  input  lsu_pkg::reg_idx_t i_rs2,
  output lsu_pkg::xlen_t    o_rs1_data,
  output lsu_pkg::xlen_t    o_rs2_data,
  input  logic              i_ld_wr_valid,
  input  lsu_pkg::reg_idx_t i_ld_wr_rd,
  input  lsu_pkg::xlen_t    i_ld_wr_data,
  input  logic              i_ext_wr_valid,
  input  lsu_pkg::reg_idx_t i_ext_wr_rd,
  input  lsu_pkg::xlen_t    i_ext_wr_data
);
  import lsu_pkg::*;

  xlen_t r_regs [32];

  assign o_rs1_data = (i_rs1 == '0) ? '0 : r_regs[i_rs1]; // x0 hardwired
  assign o_rs2_data = (i_rs2 == '0) ? '0 : r_regs[i_rs2];

  always_ff @(posedge i_clk) begin
    if (i_ld_wr_valid && (i_ld_wr_rd != '0)) begin
      r_regs[i_ld_wr_rd] <= i_ld_wr_data;
    end
    if (i_ext_wr_valid && (i_ext_wr_rd != '0)) begin
      r_regs[i_ext_wr_rd] <= i_ext_wr_data;
    end
  end

  // Issuer keeps external writes clear of load writeback slots
  a_one_writer: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !(i_ld_wr_valid && i_ext_wr_valid));

endmodule

`default_nettype wire

/* hdl/lsu_tlb.sv */
`default_nettype none

module lsu_tlb #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic          i_clk,
  input  logic          i_reset_n,
  input  lsu_pkg::vpn_t i_lookup_vpn,
  output logic          o_hit,
  output lsu_pkg::ppn_t o_ppn,
  input  logic          i_fill_valid,
  input  lsu_pkg::vpn_t i_fill_vpn,
  input  lsu_pkg::ppn_t i_fill_ppn
);
  import lsu_pkg::*;

  localparam int PTR_W = (TLB_ENTRIES > 1) ? $clog2(TLB_ENTRIES) : 1;

  logic [TLB_ENTRIES-1:0] r_valid;
  vpn_t                   r_vpn [TLB_ENTRIES];
  ppn_t                   r_ppn [TLB_ENTRIES];
  logic [PTR_W-1:0]       r_rr_ptr;

  logic [TLB_ENTRIES-1:0] w_lookup_match;
  logic [TLB_ENTRIES-1:0] w_fill_match;
  logic [PTR_W-1:0]       w_fill_idx;

  always_comb begin
    o_ppn = '0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      w_lookup_match[i] = r_valid[i] && (r_vpn[i] == i_lookup_vpn);
      if (w_lookup_match[i]) o_ppn = o_ppn | r_ppn[i];
    end
  end

  assign o_hit = |w_lookup_match;

  // Refill of a page already held reuses its slot
  always_comb begin
    w_fill_idx = r_rr_ptr;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      w_fill_match[i] = r_valid[i] && (r_vpn[i] == i_fill_vpn);
      if (w_fill_match[i]) w_fill_idx = PTR_W'(i);
    end
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid  <= '0;
      r_rr_ptr <= '0;
    end else if (i_fill_valid) begin
      r_valid[w_fill_idx] <= 1'b1;
      if (w_fill_match == '0) begin // Pointer moves only on allocation
        r_rr_ptr <= (r_rr_ptr == PTR_W'(TLB_ENTRIES-1)) ? '0 : r_rr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fill_valid) begin
      r_vpn[w_fill_idx] <= i_fill_vpn;
      r_ppn[w_fill_idx] <= i_fill_ppn;
    end
  end

  a_single_match: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    $onehot0(w_lookup_match));

endmodule

`default_nettype wire

/* hdl/lsu_top.sv */
`default_nettype none

module lsu_top #(
  parameter int TLB_ENTRIES = 4
) (
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_issue_valid,
  input  lsu_pkg::inst_t    i_issue_inst,
  input  logic              i_replay_valid,
  input  lsu_pkg::inst_t    i_replay_inst,
  output logic              o_issue_conflicted,
  input  logic              i_tlb_fill_valid,
  input  lsu_pkg::vpn_t     i_tlb_fill_vpn,
  input  lsu_pkg::ppn_t     i_tlb_fill_ppn,
  output logic              o_tlb_miss_valid,
  output lsu_pkg::vpn_t     o_tlb_miss_vpn,
  input  logic              i_ext_wr_valid,
  input  lsu_pkg::reg_idx_t i_ext_wr_rd,
  input  lsu_pkg::xlen_t    i_ext_wr_data,
  output logic              o_ld_wb_valid,
  output lsu_pkg::reg_idx_t o_ld_wb_rd,
  output lsu_pkg::xlen_t    o_ld_wb_data
);
  import lsu_pkg::*;

  inst_t     w_dec_inst;
  logic      w_dec_is_load;
  logic      w_dec_is_store;
  mem_size_t w_dec_size;
  logic      w_dec_unsigned;
  vaddr_t    w_dec_imm;
  reg_idx_t  w_dec_rs1;
  reg_idx_t  w_dec_rs2;
  reg_idx_t  w_dec_rd;
  reg_idx_t  w_rs1;
  reg_idx_t  w_rs2;
  xlen_t     w_rs1_data;
  xlen_t     w_rs2_data;
  vpn_t      w_tlb_vpn;
  logic      w_tlb_hit;
  ppn_t      w_tlb_ppn;
  paddr_t    w_ram_rd_addr;
  xlen_t     w_ram_rd_data;
  logic      w_ram_wr_valid;
  paddr_t    w_ram_wr_addr;
  byte_en_t  w_ram_wr_be;
  xlen_t     w_ram_wr_data;

  lsu_pipe u_pipe (
    .i_clk, .i_reset_n,
    .i_issue_valid, .i_issue_inst, .i_replay_valid, .i_replay_inst, .o_issue_conflicted,
    .o_dec_inst(w_dec_inst), .i_dec_is_load(w_dec_is_load), .i_dec_is_store(w_dec_is_store),
    .i_dec_size(w_dec_size), .i_dec_unsigned(w_dec_unsigned), .i_dec_imm(w_dec_imm),
    .i_dec_rs1(w_dec_rs1), .i_dec_rs2(w_dec_rs2), .i_dec_rd(w_dec_rd),
    .o_rs1(w_rs1), .o_rs2(w_rs2), .i_rs1_data(w_rs1_data), .i_rs2_data(w_rs2_data),
    .o_tlb_vpn(w_tlb_vpn), .i_tlb_hit(w_tlb_hit), .i_tlb_ppn(w_tlb_ppn),
    .o_tlb_miss_valid, .o_tlb_miss_vpn,
    .o_ram_rd_addr(w_ram_rd_addr), .i_ram_rd_data(w_ram_rd_data),
    .o_ram_wr_valid(w_ram_wr_valid), .o_ram_wr_addr(w_ram_wr_addr),
    .o_ram_wr_be(w_ram_wr_be), .o_ram_wr_data(w_ram_wr_data),
    .o_ld_wb_valid, .o_ld_wb_rd, .o_ld_wb_data
  );

  lsu_inst_decode u_decode (
    .i_inst(w_dec_inst), .o_is_load(w_dec_is_load), .o_is_store(w_dec_is_store),
    .o_size(w_dec_size), .o_unsigned(w_dec_unsigned), .o_imm(w_dec_imm),
    .o_rs1(w_dec_rs1), .o_rs2(w_dec_rs2), .o_rd(w_dec_rd)
  );

  lsu_tlb #(.TLB_ENTRIES(TLB_ENTRIES)) u_tlb (
    .i_clk, .i_reset_n,
    .i_lookup_vpn(w_tlb_vpn), .o_hit(w_tlb_hit), .o_ppn(w_tlb_ppn),
    .i_fill_valid(i_tlb_fill_valid), .i_fill_vpn(i_tlb_fill_vpn), .i_fill_ppn(i_tlb_fill_ppn)
  );

  // Load result is written back one cycle after it is reported
  lsu_regfile u_regfile (
    .i_clk, .i_reset_n,
    .i_rs1(w_rs1), .i_rs2(w_rs2), .o_rs1_data(w_rs1_data), .o_rs2_data(w_rs2_data),
    .i_ld_wr_valid(o_ld_wb_valid), .i_ld_wr_rd(o_ld_wb_rd), .i_ld_wr_data(o_ld_wb_data),
    .i_ext_wr_valid, .i_ext_wr_rd, .i_ext_wr_data
  );

  lsu_data_ram u_ram (
    .i_clk,
    .i_rd_addr(w_ram_rd_addr), .o_rd_data(w_ram_rd_data),
    .i_wr_valid(w_ram_wr_valid), .i_wr_addr(w_ram_wr_addr),
    .i_wr_be(w_ram_wr_be), .i_wr_data(w_ram_wr_data)
  );

endmodule

`default_nettype wire

/* list.f */
hdl/lsu_pkg.sv
hdl/lsu_inst_decode.sv
hdl/lsu_tlb.sv
hdl/lsu_regfile.sv
hdl/lsu_data_ram.sv
hdl/lsu_pipe.sv
hdl/lsu_top.sv
test/tb_clock_gen.sv
test/tb_lsu_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_lsu_top \
  -o sim_lsu &&
out="$(./obj_dir/sim_lsu)" &&
echo "$out" &&
echo "$out" | grep -qx "PASS: all tests" ||
{ echo "Simulation did not pass"; exit 1; }

/* test/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk; // 20 ns period
  end

  // Held over the first two rising edges
  initial begin
    o_reset_n = 1'b0;
    #40;
    o_reset_n = 1'b1;
  end

endmodule

`default_nettype wire

/* test/tb_lsu_top.sv */
`default_nettype none

module tb_lsu_top;
  timeunit 1ns;
  timeprecision 1ps;
  import lsu_pkg::*;

  localparam int N_TLB = 4;
  localparam int LIMIT = 4000;

  logic clk, reset_n;
  logic i_issue_valid, i_replay_valid, i_tlb_fill_valid, i_ext_wr_valid;
  inst_t i_issue_inst, i_replay_inst;
  vpn_t i_tlb_fill_vpn;
  ppn_t i_tlb_fill_ppn;
  reg_idx_t i_ext_wr_rd;
  xlen_t i_ext_wr_data;
  logic o_issue_conflicted, o_tlb_miss_valid, o_ld_wb_valid;
  vpn_t o_tlb_miss_vpn;
  reg_idx_t o_ld_wb_rd;
  xlen_t o_ld_wb_data;

  int cyc;
  int errors;
  xlen_t regs [32];
  logic [7:0] mem_model [int]; // Byte image keyed by physical address
  logic tlb_v [N_TLB];
  vpn_t tlb_vpn [N_TLB];
  ppn_t tlb_ppn [N_TLB];
  int rr;
  int wb_due [$];
  reg_idx_t wb_rd [$];
  xlen_t wb_data [$];
  int miss_due [$];
  vpn_t miss_vpn [$];
  int conf_due [$];
  logic pend_v; // Issue that sits in EX0 next cycle
  inst_t pend_inst;
  vaddr_t vbase [5];
  inst_t inst_a;

  tb_clock_gen u_clk (.o_clk(clk), .o_reset_n(reset_n));

  lsu_top #(.TLB_ENTRIES(N_TLB)) i_dut (
    .i_clk(clk), .i_reset_n(reset_n),
    .i_issue_valid, .i_issue_inst, .i_replay_valid, .i_replay_inst, .o_issue_conflicted,
    .i_tlb_fill_valid, .i_tlb_fill_vpn, .i_tlb_fill_ppn, .o_tlb_miss_valid, .o_tlb_miss_vpn,
    .i_ext_wr_valid, .i_ext_wr_rd, .i_ext_wr_data, .o_ld_wb_valid, .o_ld_wb_rd, .o_ld_wb_data
  );

  function automatic inst_t enc_load(int rd, int rs1, logic [2:0] f3, int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], 7'b0000011};
  endfunction

  function automatic inst_t enc_store(int rs2, int rs1, logic [2:0] f3, int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic inst_t rand_mem();
    int sz;
    int ofs;
    int base;
    logic uns;
    sz = $urandom % 4;
    base = 1 + $urandom % 4;
    ofs = ($urandom % 2048) & ~((1 << sz) - 1); // Naturally aligned
    uns = ($urandom % 2 == 1) && (sz != 3);
    if ($urandom % 2 == 1) return enc_load(10 + $urandom % 22, base, {uns, sz[1:0]}, ofs);
    return enc_store(5 + $urandom % 5, base, {1'b0, sz[1:0]}, ofs);
  endfunction

  function automatic inst_t rand_nonmem();
    inst_t w;
    w = $urandom;
    case ($urandom % 3)
      0: w[6:0] = 7'b0010011;
      1: w = {w[31:15], 3'b111, w[11:7], 7'b0000011}; // Reserved load funct3
      default: w = {w[31:15], 1'b1, w[13:7], 7'b0100011};
    endcase
    return w;
  endfunction

  function automatic logic [7:0] mem_rd(int a);
    return mem_model.exists(a) ? mem_model[a] : 8'h00;
  endfunction

  task automatic fill_model(vpn_t vpn, ppn_t ppn);
    int slot;
    slot = -1;
    for (int i = 0; i < N_TLB; i++) if (tlb_v[i] && tlb_vpn[i] == vpn) slot = i;
    if (slot < 0) begin
      slot = rr;
      rr = (rr + 1) % N_TLB;
    end
    tlb_v[slot] = 1'b1;
    tlb_vpn[slot] = vpn;
    tlb_ppn[slot] = ppn;
  endtask

  // Reference for one instruction occupying EX0 in cycle ex0
  task automatic execute(inst_t inst, int ex0);
    logic [2:0] f3;
    vaddr_t imm;
    vaddr_t va;
    int slot;
    int pa;
    int bytes;
    xlen_t v;
    f3 = inst[14:12];
    if (inst[6:0] == 7'b0000011 && f3 != 3'b111) imm = {{20{inst[31]}}, inst[31:20]};
    else if (inst[6:0] == 7'b0100011 && !f3[2]) imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    else return;
    va = regs[inst[19:15]][31:0] + imm;
    slot = -1;
    for (int i = 0; i < N_TLB; i++) if (tlb_v[i] && tlb_vpn[i] == va[31:12]) slot = i;
    if (slot < 0) begin
      miss_due.push_back(ex0 + 1);
      miss_vpn.push_back(va[31:12]);
      return;
    end
    pa = {tlb_ppn[slot], va[11:0]};
    bytes = 1 << f3[1:0];
    v = '0;
    if (inst[5]) begin
      for (int b = 0; b < bytes; b++) mem_model[pa + b] = regs[inst[24:20]][8*b +: 8];
    end else begin
      for (int b = 0; b < bytes; b++) v[8*b +: 8] = mem_rd(pa + b);
      if (!f3[2] && bytes < 8 && v[8*bytes-1]) v = v | (~64'd0 << (8 * bytes));
      wb_due.push_back(ex0 + 3);
      wb_rd.push_back(inst[11:7]);
      wb_data.push_back(v);
      if (inst[11:7] != 5'd0) regs[inst[11:7]] = v;
    end
  endtask

  // Models the inputs of this cycle and waits for the next falling edge
  task automatic tick();
    if (i_tlb_fill_valid) fill_model(i_tlb_fill_vpn, i_tlb_fill_ppn);
    if (i_ext_wr_valid && i_ext_wr_rd != 5'd0) regs[i_ext_wr_rd] = i_ext_wr_data;
    if (pend_v && i_replay_valid) conf_due.push_back(cyc); // Issue dropped
    else if (pend_v) execute(pend_inst, cyc);
    if (i_replay_valid) execute(i_replay_inst, cyc);
    pend_v = i_issue_valid;
    pend_inst = i_issue_inst;
    @(negedge clk);
    i_issue_valid = 1'b0;
    i_replay_valid = 1'b0;
    i_tlb_fill_valid = 1'b0;
    i_ext_wr_valid = 1'b0;
  endtask

  task automatic idle(int n);
    repeat (n) tick();
  endtask

  task automatic report_value(string name, xlen_t exp, xlen_t got);
    $display("CHECK FAILED %s expected %h got %h at cycle %0d", name, exp, got, cyc);
    errors++;
  endtask

  task automatic check_outputs();
    if (wb_due.size() > 0 && wb_due[0] == cyc) begin
      if (o_ld_wb_valid !== 1'b1) report_value("o_ld_wb_valid", 1, o_ld_wb_valid);
      if (o_ld_wb_rd !== wb_rd[0]) report_value("o_ld_wb_rd", wb_rd[0], o_ld_wb_rd);
      if (o_ld_wb_data !== wb_data[0]) report_value("o_ld_wb_data", wb_data[0], o_ld_wb_data);
      void'(wb_due.pop_front());
      void'(wb_rd.pop_front());
      void'(wb_data.pop_front());
    end else if (o_ld_wb_valid !== 1'b0) report_value("o_ld_wb_valid", 0, o_ld_wb_valid);
    if (miss_due.size() > 0 && miss_due[0] == cyc) begin
      if (o_tlb_miss_valid !== 1'b1) report_value("o_tlb_miss_valid", 1, o_tlb_miss_valid);
      if (o_tlb_miss_vpn !== miss_vpn[0]) begin
        report_value("o_tlb_miss_vpn", miss_vpn[0], o_tlb_miss_vpn);
      end
      void'(miss_due.pop_front());
      void'(miss_vpn.pop_front());
    end else if (o_tlb_miss_valid !== 1'b0) report_value("o_tlb_miss_valid", 0, o_tlb_miss_valid);
    if (conf_due.size() > 0 && conf_due[0] == cyc) begin
      if (o_issue_conflicted !== 1'b1) report_value("o_issue_conflicted", 1, o_issue_conflicted);
      void'(conf_due.pop_front());
    end else if (o_issue_conflicted !== 1'b0) begin
      report_value("o_issue_conflicted", 0, o_issue_conflicted);
    end
  endtask

  always @(posedge clk) begin
    if (reset_n) cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("Timeout: run passed %0d cycles", LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  always @(negedge clk) begin
    #2; // Inputs of this cycle have settled
    if (reset_n) check_outputs();
  end

  initial begin
    i_issue_valid = 1'b0;
    i_issue_inst = '0;
    i_replay_valid = 1'b0;
    i_replay_inst = '0;
    i_tlb_fill_valid = 1'b0;
    i_tlb_fill_vpn = '0;
    i_tlb_fill_ppn = '0;
    i_ext_wr_valid = 1'b0;
    i_ext_wr_rd = '0;
    i_ext_wr_data = '0;
    cyc = 0;
    errors = 0;
    rr = 0;
    pend_v = 1'b0;
    for (int i = 0; i < 32; i++) regs[i] = '0;
    for (int i = 0; i < N_TLB; i++) tlb_v[i] = 1'b0;
    void'($urandom(32'h9f771ffe));
    @(posedge reset_n);
    @(posedge clk);
    @(negedge clk);
    for (int i = 0; i < 5; i++) vbase[i] = 32'h0004_0000 + 32'(i) * 32'h3000;
    for (int r = 1; r <= 9; r++) begin
      i_ext_wr_valid = 1'b1;
      i_ext_wr_rd = r[4:0];
      i_ext_wr_data = (r <= 4) ? xlen_t'(vbase[r-1]) : {$urandom, $urandom};
      tick();
    end
    idle(2);
    // First touch of each page misses before fill and replay
    for (int i = 0; i < 4; i++) begin
      inst_a = (i % 2 == 0) ? enc_store(5 + i, 1 + i, 3'b011, 8 * i) :
                              enc_load(10 + i, 1 + i, 3'b011, 8 * i);
      i_issue_valid = 1'b1;
      i_issue_inst = inst_a;
      tick();
      idle(4);
      i_tlb_fill_valid = 1'b1;
      i_tlb_fill_vpn = vbase[i][31:12];
      i_tlb_fill_ppn = ppn_t'(i + 1);
      idle(2);
      i_replay_valid = 1'b1;
      i_replay_inst = inst_a;
      idle(5);
    end
    i_issue_valid = 1'b1;
    i_issue_inst = enc_load(11, 1, 3'b011, 0);
    tick();
    i_issue_valid = 1'b1;
    i_issue_inst = enc_load(12, 3, 3'b011, 16);
    idle(5);
    // Replay beats a fresh issue that is resent later
    inst_a = enc_load(13, 2, 3'b010, 64);
    i_issue_valid = 1'b1;
    i_issue_inst = inst_a;
    tick();
    i_replay_valid = 1'b1;
    i_replay_inst = enc_load(14, 3, 3'b100, 5);
    idle(5);
    i_issue_valid = 1'b1;
    i_issue_inst = inst_a;
    idle(5);
    repeat (1200) begin
      i_issue_valid = ($urandom % 8 != 0);
      i_issue_inst = ($urandom % 5 == 0) ? rand_nonmem() : rand_mem();
      i_replay_valid = ($urandom % 10 == 0);
      i_replay_inst = rand_mem();
      tick();
    end
    idle(5);
    // A fifth page evicts the round-robin victim
    i_ext_wr_valid = 1'b1;
    i_ext_wr_rd = 5'd10;
    i_ext_wr_data = xlen_t'(vbase[4]);
    tick();
    i_tlb_fill_valid = 1'b1;
    i_tlb_fill_vpn = vbase[4][31:12];
    i_tlb_fill_ppn = ppn_t'(5);
    idle(2);
    for (int i = 0; i < 5; i++) begin
      i_issue_valid = 1'b1;
      i_issue_inst = enc_load(20 + i, (i < 4) ? 1 + i : 10, 3'b011, 24);
      tick();
    end
    idle(6);
    if (wb_due.size() != 0 || miss_due.size() != 0 || conf_due.size() != 0) begin
      $display("Expected responses never appeared on the DUT outputs");
      errors++;
    end
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire
